/* vlog.f */
+incdir+bench
common/elevator_pkg.sv
source/call_register.sv
source/car_controller.sv
source/matrix_display.sv
source/elevator_top.sv
bench/elevator_tb.sv

/* Bender.yml */
package:
  name: elevator

sources:
  # shared package
  - files:
      - common/elevator_pkg.sv
  # design
  - files:
      - source/call_register.sv
      - source/car_controller.sv
      - source/matrix_display.sv
      - source/elevator_top.sv
  # testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/elevator_tb.sv

/* bench/elevator_tests.svh */
`ifndef ELEVATOR_TESTS_SVH
`define ELEVATOR_TESTS_SVH

        ////////////////////////////////////////////////////////////
        // stimulus and car model
        ////////////////////////////////////////////////////////////

        // buttons high for one clock and lamps looked at after the sampling edge
        task automatic press_buttons(input floor_mask_t land, input floor_mask_t cab);
                @(posedge clk_50hz);
                floor_p <= land;
                floor_d <= cab;
                @(posedge clk_50hz);
                floor_p <= '0;
                floor_d <= '0;
                @(negedge clk_50hz);
                check_value(led_outside, land, "landing lamps after press");
                check_value(led_inside, cab, "cab lamps after press");
        endtask

        task automatic wait_door_open(input int limit, output int cycles);
                logic opened;
                cycles = 0;
                opened = 1'b0;
                while (!opened && cycles < limit)
                begin
                        @(negedge clk_50hz);
                        cycles++;
                        opened = door_open;
                end
                if (!opened)
                begin
                        $display("door did not open within %0d cycles at %0t", limit, $time);
                        error_count++;
                end
        endtask

        task automatic hold_door(input int fl, output int cycles);
                logic closed;
                cycles = 0;
                closed = 1'b0;
                while (!closed && cycles < DOOR_TICKS + 4)
                begin
                        @(negedge clk_50hz);
                        cycles++;
                        closed = !door_open;
                        if (cycles == 1)
                        begin
                                check_value(led_inside[fl], 1'b0, "cab lamp at door open");
                                check_value(led_outside[fl], 1'b0, "landing lamp at door open");
                        end
                end
                if (!closed)
                begin
                        $display("door stayed open too long at floor %0d at %0t", fl, $time);
                        error_count++;
                end
        endtask

        function automatic logic calls_ahead(input floor_mask_t mask, input int cur,
                                             input logic up);
                logic found;
                found = 1'b0;
                for (int i = 0; i < NUM_FLOORS; i++)
                        if (mask[i] && (up ? (i > cur) : (i < cur)))
                                found = 1'b1;
                return found;
        endfunction

        // collective order keeps going while calls lie ahead and then turns
        task automatic predict_stops(input floor_mask_t calls);
                floor_mask_t left;
                left = calls;
                stop_floor_q.delete();
                stop_up_q.delete();
                if (left[model_floor])
                begin
                        stop_floor_q.push_back(model_floor);
                        stop_up_q.push_back(model_up);
                        left[model_floor] = 1'b0;
                end
                while (left != '0)
                begin
                        if (!calls_ahead(left, model_floor, model_up))
                                model_up = !model_up;
                        model_floor = model_up ? model_floor + 1 : model_floor - 1;
                        if (left[model_floor])
                        begin
                                stop_floor_q.push_back(model_floor);
                                stop_up_q.push_back(model_up);
                                left[model_floor] = 1'b0;
                        end
                end
        endtask

        ////////////////////////////////////////////////////////////
        // directed tests
        ////////////////////////////////////////////////////////////

        task automatic idle_after_reset();
                check_value(led_inside, 0, "cab lamps after reset");
                check_value(led_outside, 0, "landing lamps after reset");
                check_value(door_open, 1'b0, "door after reset");
                verify_display(0, 1'b0, 1'b1, "after reset");
        endtask

        task automatic serve_call_here();
                int cycles;
                press_buttons(5'b00000, 5'b00001);
                wait_door_open(4, cycles);
                check_value(cycles, 1, "door delay for call at current floor");
                verify_display(0, 1'b1, 1'b1, "door open at floor 0");
                hold_door(0, cycles);
                check_value(cycles, DOOR_TICKS, "door dwell at floor 0");
                verify_display(0, 1'b0, 1'b1, "idle at floor 0");
        endtask

        task automatic travel_up();
                int   cycles;
                logic opened;
                press_buttons(5'b01000, 5'b00000);
                cycles = 0;
                opened = 1'b0;
                while (!opened && cycles < 3 * MOVE_TICKS + 4)
                begin
                        @(negedge clk_50hz);
                        cycles++;
                        opened = door_open;
                        if (!opened)
                                verify_display((cycles - 1) / MOVE_TICKS, 1'b1, 1'b1, "going up");
                end
                if (!opened)
                begin
                        $display("door did not open at floor 3 at %0t", $time);
                        error_count++;
                end
                check_value(cycles, 1 + 3 * MOVE_TICKS, "door delay three floors up");
                verify_display(3, 1'b1, 1'b1, "door open at floor 3");
                hold_door(3, cycles);
                check_value(cycles, DOOR_TICKS, "door dwell at floor 3");
                verify_display(3, 1'b0, 1'b1, "idle at floor 3");
                model_floor = 3;
        endtask

        task automatic collective_stops();
                int cycles;
                press_buttons(5'b00010, 5'b10000);
                wait_door_open(1 + MOVE_TICKS + 4, cycles);
                check_value(cycles, 1 + MOVE_TICKS, "door delay for stop at floor 4");
                verify_display(4, 1'b1, 1'b1, "door open at floor 4");
                hold_door(4, cycles);
                check_value(cycles, DOOR_TICKS, "door dwell at floor 4");
                check_value(led_inside, 0, "cab lamps after floor 4");
                check_value(led_outside, 5'b00010, "landing lamps after floor 4");
                verify_display(4, 1'b1, 1'b0, "leaving floor 4 downward");
                wait_door_open(3 * MOVE_TICKS + 4, cycles);
                check_value(cycles, 3 * MOVE_TICKS, "door delay for stop at floor 1");
                verify_display(1, 1'b1, 1'b0, "door open at floor 1");
                hold_door(1, cycles);
                check_value(cycles, DOOR_TICKS, "door dwell at floor 1");
                check_value(led_outside, 0, "landing lamps after floor 1");
                verify_display(1, 1'b0, 1'b0, "idle at floor 1");
                model_floor = 1;
                model_up    = 1'b0;
        endtask

        task automatic random_calls();
                logic [31:0] land;
                logic [31:0] cab;
                int          cycles;
                int          fl;
                for (int n = 0; n < ROUNDS; n++)
                begin
                        random_bits(NUM_FLOORS, land);
                        random_bits(NUM_FLOORS, cab);
                        if ((land | cab) == 0)
                                land[TOP_FLOOR] = 1'b1;         // at least one call
                        press_buttons(floor_mask_t'(land), floor_mask_t'(cab));
                        predict_stops(floor_mask_t'(land | cab));
                        while (stop_floor_q.size() > 0)
                        begin
                                fl = stop_floor_q.pop_front();
                                wait_door_open(TOP_FLOOR * MOVE_TICKS + 4, cycles);
                                verify_display(fl, 1'b1, stop_up_q.pop_front(), "random stop");
                                hold_door(fl, cycles);
                                check_value(cycles, DOOR_TICKS, "door dwell on random stop");
                        end
                        check_value(led_inside, 0, "cab lamps after random calls");
                        check_value(led_outside, 0, "landing lamps after random calls");
                        verify_display(model_floor, 1'b0, model_up, "idle after random calls");
                end
        endtask

`endif

/* bench/elevator_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module elevator_tb;

        import elevator_pkg::*;

        localparam int CLK_PERIOD  = 8;
        localparam int ROUNDS      = 3;                 // random call rounds
        localparam int TRIP_CYCLES = 2 * TOP_FLOOR * MOVE_TICKS
                                   + NUM_FLOORS * (DOOR_TICKS + 2) + 16;
        localparam int RUN_CYCLES  = (4 + ROUNDS) * TRIP_CYCLES;
        localparam logic [31:0] LFSR_SEED = 32'h661f17a4;

        logic        clk_50hz;
        logic        rst;
        floor_mask_t floor_p;
        floor_mask_t floor_d;
        floor_mask_t led_inside;
        floor_mask_t led_outside;
        logic        door_open;
        row_t        a, b, c, d, e, f, g, p;
        int          error_count;
        int          check_count;
        int          model_floor;                       // where the car rests
        logic        model_up;
        logic [31:0] lfsr_state;
        int          stop_floor_q [$];                  // predicted door openings
        logic        stop_up_q [$];

        initial
        begin
                clk_50hz = 1'b0;
                forever #(CLK_PERIOD / 2) clk_50hz = ~clk_50hz;
        end

        elevator_top UUT (
                .clk_50hz    (clk_50hz),
                .rst         (rst),
                .floor_p     (floor_p),
                .floor_d     (floor_d),
                .led_inside  (led_inside),
                .led_outside (led_outside),
                .door_open   (door_open),
                .a (a), .b (b), .c (c), .d (d),
                .e (e), .f (f), .g (g), .p (p)
        );

        ////////////////////////////////////////////////////////////
        // random source and checking
        ////////////////////////////////////////////////////////////

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        task automatic random_bits(input int n, output logic [31:0] value);
                value = '0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr_state = lfsr_next(lfsr_state);     // one step per bit
                        value      = {value[30:0], lfsr_state[0]};
                end
        endtask

        task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                                   input string what);
                check_count++;
                if (actual !== expected)
                begin
                        $display("ERROR at %0t: %s: got %0h, expected %0h",
                                 $time, what, actual, expected);
                        error_count++;
                end
        endtask

        // digit glyph with the arrow cut into the upper columns
        function automatic row_t expected_row(input int fl, input int r, input logic arrow,
                                              input logic up);
                row_t row;
                row = DIGIT_GLYPH[fl][r];
                if (arrow && up)
                        row = row & ARROW_UP_MASK[r];
                else if (arrow)
                        row = row & ARROW_DOWN_MASK[r];
                return row;
        endfunction

        task automatic verify_display(input int fl, input logic arrow, input logic up,
                                      input string what);
                check_value(a, expected_row(fl, 0, arrow, up), {what, ", row a"});
                check_value(b, expected_row(fl, 1, arrow, up), {what, ", row b"});
                check_value(c, expected_row(fl, 2, arrow, up), {what, ", row c"});
                check_value(d, expected_row(fl, 3, arrow, up), {what, ", row d"});
                check_value(e, expected_row(fl, 4, arrow, up), {what, ", row e"});
                check_value(f, expected_row(fl, 5, arrow, up), {what, ", row f"});
                check_value(g, expected_row(fl, 6, arrow, up), {what, ", row g"});
                check_value(p, BLANK_ROW, {what, ", row p"});
        endtask

        `include "elevator_tests.svh"

        initial
        begin
                #(RUN_CYCLES * CLK_PERIOD);
                $display("watchdog timeout, tests did not finish within %0d cycles", RUN_CYCLES);
                $display("Simulation finished: FAIL");
                $finish;
        end

        initial
        begin
                error_count = 0;
                check_count = 0;
                model_floor = 0;
                model_up    = 1'b1;
                lfsr_state  = LFSR_SEED;
                rst         = 1'b1;
                floor_p     = '0;
                floor_d     = '0;
                repeat (2) @(posedge clk_50hz);
                rst <= 1'b0;
                @(negedge clk_50hz);
                idle_after_reset();
                serve_call_here();
                travel_up();
                collective_stops();
                random_calls();
                $display("checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

/* source/elevator_top.sv */
`timescale 1ns/10ps
`default_nettype none

module elevator_top
(
        input  wire logic                      clk_50hz,
        input  wire logic                      rst,
        input  wire elevator_pkg::floor_mask_t floor_p,        // landing buttons
        input  wire elevator_pkg::floor_mask_t floor_d,        // cab buttons
        output wire elevator_pkg::floor_mask_t led_inside,
        output wire elevator_pkg::floor_mask_t led_outside,
        output wire logic                      door_open,
        output wire elevator_pkg::row_t        a,
        output wire elevator_pkg::row_t        b,
        output wire elevator_pkg::row_t        c,
        output wire elevator_pkg::row_t        d,
        output wire elevator_pkg::row_t        e,
        output wire elevator_pkg::row_t        f,
        output wire elevator_pkg::row_t        g,
        output wire elevator_pkg::row_t        p
);

        import elevator_pkg::*;

        floor_mask_t pending;
        floor_t      current_floor;
        dir_t        direction;
        car_state_t  state;

        call_register u_call_register (
                .clk_50hz      (clk_50hz),
                .rst           (rst),
                .floor_p       (floor_p),
                .floor_d       (floor_d),
                .door_open     (door_open),
                .current_floor (current_floor),
                .led_inside    (led_inside),
                .led_outside   (led_outside),
                .pending       (pending)
        );

        car_controller u_car_controller (
                .clk_50hz      (clk_50hz),
                .rst           (rst),
                .pending       (pending),
                .door_open     (door_open),
                .current_floor (current_floor),
                .direction     (direction),
                .state         (state)
        );

        matrix_display u_matrix_display (
                .current_floor (current_floor),
                .direction     (direction),
                .state         (state),
                .a (a), .b (b), .c (c), .d (d),
                .e (e), .f (f), .g (g), .p (p)
        );

endmodule

`default_nettype wire

/* source/matrix_display.sv */
`timescale 1ns/10ps
`default_nettype none

module matrix_display
(
        input  wire elevator_pkg::floor_t     current_floor,
        input  wire elevator_pkg::dir_t       direction,
        input  wire elevator_pkg::car_state_t state,
        output elevator_pkg::row_t            a,
        output elevator_pkg::row_t            b,
        output elevator_pkg::row_t            c,
        output elevator_pkg::row_t            d,
        output elevator_pkg::row_t            e,
        output elevator_pkg::row_t            f,
        output elevator_pkg::row_t            g,
        output elevator_pkg::row_t            p
);

        import elevator_pkg::*;

        row_t   rows [7];                               // rows a to g
        floor_t glyph_floor;
        logic   show_arrow;

        // out of range floors fall back to the top digit
        assign glyph_floor = (current_floor > floor_t'(TOP_FLOOR)) ? floor_t'(TOP_FLOOR)
                                                                   : current_floor;
        assign show_arrow  = (state != CAR_IDLE);

        ////////////////////////////////////////////////////////////
        // digit with arrow overlay
        ////////////////////////////////////////////////////////////

        always_comb
        begin
                for (int r = 0; r < 7; r++)
                begin
                        rows[r] = DIGIT_GLYPH[glyph_floor][r];
                        if (show_arrow)
                        begin
                                if (direction == DIR_UP)
                                        rows[r] = rows[r] & ARROW_UP_MASK[r];
                                else
                                        rows[r] = rows[r] & ARROW_DOWN_MASK[r];
                        end
                end
        end

        assign a = rows[0];
        assign b = rows[1];
        assign c = rows[2];
        assign d = rows[3];
        assign e = rows[4];
        assign f = rows[5];
        assign g = rows[6];
        assign p = BLANK_ROW;                           // unused row stays dark

endmodule

`default_nettype wire

/* source/car_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module car_controller
(
        input  wire logic                      clk_50hz,
        input  wire logic                      rst,
        input  wire elevator_pkg::floor_mask_t pending,
        output logic                           door_open,
        output elevator_pkg::floor_t           current_floor,
        output elevator_pkg::dir_t             direction,
        output elevator_pkg::car_state_t       state
);

        import elevator_pkg::*;

        logic [TIMER_W-1:0] timer;                      // move or door ticks
        floor_mask_t        above_mask;
        floor_mask_t        below_mask;
        logic               call_here;
        logic               call_above;
        logic               call_below;
        logic               call_ahead;
        logic               call_behind;
        logic               call_at_step;
        logic               move_done;
        logic               door_done;
        floor_t             step_floor;
        dir_t               reverse_dir;

        ////////////////////////////////////////////////////////////
        // where the calls lie
        ////////////////////////////////////////////////////////////

        always_comb
        begin
                for (int i = 0; i < NUM_FLOORS; i++)
                begin
                        above_mask[i] = (floor_t'(i) > current_floor);
                        below_mask[i] = (floor_t'(i) < current_floor);
                end
        end

        assign call_here   = pending[current_floor];
        assign call_above  = |(pending & above_mask);
        assign call_below  = |(pending & below_mask);
        assign call_ahead  = (direction == DIR_UP) ? call_above : call_below;
        assign call_behind = (direction == DIR_UP) ? call_below : call_above;
        assign reverse_dir = (direction == DIR_UP) ? DIR_DOWN : DIR_UP;

        // next floor in the travel direction
        assign step_floor   = (direction == DIR_UP) ? current_floor + 3'd1
                                                    : current_floor - 3'd1;
        assign call_at_step = pending[step_floor];

        assign move_done = (timer == TIMER_W'(MOVE_TICKS - 1));
        assign door_done = (timer == TIMER_W'(DOOR_TICKS - 1));
        assign door_open = (state == CAR_DOOR_OPEN);

        ////////////////////////////////////////////////////////////
        // car FSM
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_50hz or posedge rst)
        begin
                if (rst)
                begin
                        state         <= CAR_IDLE;
                        current_floor <= '0;
                        direction     <= DIR_UP;
                        timer         <= '0;
                end
                else
                begin
                        case (state)
                        CAR_IDLE:
                        begin
                                timer <= '0;
                                if (call_here)
                                        state <= CAR_DOOR_OPEN;
                                else if (call_ahead)
                                        state <= CAR_MOVING;
                                else if (call_behind)
                                begin
                                        state     <= CAR_MOVING;
                                        direction <= reverse_dir;
                                end
                        end
                        CAR_MOVING:
                        begin
                                if (move_done)
                                begin
                                        timer         <= '0;
                                        current_floor <= step_floor;
                                        if (call_at_step)
                                                state <= CAR_DOOR_OPEN;     // stop here
                                end
                                else
                                        timer <= timer + 1'b1;
                        end
                        CAR_DOOR_OPEN:
                        begin
                                if (door_done)
                                begin
                                        timer <= '0;
                                        // keep going, then turn, then rest
                                        if (call_ahead)
                                                state <= CAR_MOVING;
                                        else if (call_behind)
                                        begin
                                                state     <= CAR_MOVING;
                                                direction <= reverse_dir;
                                        end
                                        else
                                                state <= CAR_IDLE;
                                end
                                else
                                        timer <= timer + 1'b1;
                        end
                        default:
                        begin
                                state <= CAR_IDLE;
                                timer <= '0;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* source/call_register.sv */
`timescale 1ns/10ps
`default_nettype none

module call_register
(
        input  wire logic                      clk_50hz,
        input  wire logic                      rst,
        input  wire elevator_pkg::floor_mask_t floor_p,        // landing buttons
        input  wire elevator_pkg::floor_mask_t floor_d,        // cab buttons
        input  wire logic                      door_open,
        input  wire elevator_pkg::floor_t      current_floor,
        output elevator_pkg::floor_mask_t      led_inside,
        output elevator_pkg::floor_mask_t      led_outside,
        output elevator_pkg::floor_mask_t      pending
);

        import elevator_pkg::*;

        floor_mask_t serve_mask;

        ////////////////////////////////////////////////////////////
        // floor being served
        ////////////////////////////////////////////////////////////

        always_comb
        begin
                for (int i = 0; i < NUM_FLOORS; i++)
                begin
                        serve_mask[i] = door_open && (current_floor == floor_t'(i));
                end
        end

        ////////////////////////////////////////////////////////////
        // lamp latches
        ////////////////////////////////////////////////////////////

        // clear beats a press on the same edge
        always_ff @(posedge clk_50hz or posedge rst)
        begin
                if (rst)
                begin
                        led_inside  <= '0;
                        led_outside <= '0;
                end
                else
                begin
                        for (int i = 0; i < NUM_FLOORS; i++)
                        begin
                                if (serve_mask[i])
                                begin
                                        led_inside[i]  <= 1'b0;
                                        led_outside[i] <= 1'b0;
                                end
                                else
                                begin
                                        if (floor_d[i])
                                                led_inside[i] <= 1'b1;
                                        if (floor_p[i])
                                                led_outside[i] <= 1'b1;
                                end
                        end
                end
        end

        // any lamp lit means the car owes a stop
        assign pending = led_inside | led_outside;

endmodule

`default_nettype wire

/* common/elevator_pkg.sv */
`default_nettype none

package elevator_pkg;

        ////////////////////////////////////////////////////////////
        // car geometry and timing
        ////////////////////////////////////////////////////////////

        localparam int NUM_FLOORS = 5;
        localparam int TOP_FLOOR  = NUM_FLOORS - 1;
        localparam int MOVE_TICKS = 120;        // clocks per floor of travel
        localparam int DOOR_TICKS = 120;        // clocks of door dwell
        localparam int TIMER_W    = 8;          // covers both tick counts

        typedef logic [2:0]            floor_t;
        typedef logic [NUM_FLOORS-1:0] floor_mask_t;
        typedef logic [7:0]            row_t;   // active low dots

        typedef enum logic [1:0] {
                CAR_IDLE,
                CAR_MOVING,
                CAR_DOOR_OPEN
        } car_state_t;

        typedef enum logic {
                DIR_DOWN,
                DIR_UP
        } dir_t;

        ////////////////////////////////////////////////////////////
        // dot matrix glyphs for rows a to g
        ////////////////////////////////////////////////////////////

        localparam row_t BLANK_ROW = 8'b1111_1111;

        // digit sits in the low four columns
        localparam row_t DIGIT_GLYPH [NUM_FLOORS][7] = '{
                '{8'b1111_0110, 8'b1111_1110, 8'b1111_1110, 8'b1111_1010,
                  8'b1111_0010, 8'b1111_0010, 8'b1111_0111},   // floor 0
                '{8'b1111_0111, 8'b1111_1110, 8'b1111_1110, 8'b1111_1011,
                  8'b1111_0011, 8'b1111_0011, 8'b1111_0111},   // floor 1
                '{8'b1111_0110, 8'b1111_1110, 8'b1111_1111, 8'b1111_1010,
                  8'b1111_0010, 8'b1111_0011, 8'b1111_0110},   // floor 2
                '{8'b1111_0110, 8'b1111_1110, 8'b1111_1110, 8'b1111_1010,
                  8'b1111_0011, 8'b1111_0011, 8'b1111_0110},   // floor 3
                '{8'b1111_0111, 8'b1111_1110, 8'b1111_1110, 8'b1111_1011,
                  8'b1111_0011, 8'b1111_0010, 8'b1111_0110}    // floor 4
        };

        localparam row_t ARROW_UP_MASK [7] = '{
                8'b1110_1111,
                8'b1100_1111,
                8'b1101_1111,
                8'b1101_1111,
                8'b1100_1111,
                8'b1100_1111,
                8'b1110_1111
        };

        localparam row_t ARROW_DOWN_MASK [7] = '{
                8'b1110_1111,
                8'b1100_1111,
                8'b1100_1111,
                8'b1100_1111,
                8'b1100_1111,
                8'b1110_1111,
                8'b1101_1111
        };

endpackage

`default_nettype wire
